// File: logic/alu_exec.sv
/*
 * Single-cycle integer ALU. The result register is held while the CDB
 * arbiter is busy with a multiply result.
 */
`default_nettype none

module alu_exec (
    input  logic             clock,
    input  logic             reset,
    input  logic             flush,
    input  ooo_pkg::issue_t  issue,
    input  logic             issue_valid,
    input  logic             stall,
    output ooo_pkg::result_t result
);
    import ooo_pkg::*;

    logic [xlen-1:0] value;

    always_comb begin
        case (issue.op)
            op_add:  value = issue.opa + issue.opb;
            op_sub:  value = issue.opa - issue.opb;
            op_and:  value = issue.opa & issue.opb;
            op_or:   value = issue.opa | issue.opb;
            op_xor:  value = issue.opa ^ issue.opb;
            op_slt:  value = {{(xlen - 1){1'b0}}, $signed(issue.opa) < $signed(issue.opb)};
            op_sll:  value = issue.opa << issue.opb[4:0];   // low 5 bits only
            op_srl:  value = issue.opa >> issue.opb[4:0];
            default: value = '0;                           // multiplies never come here
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            result.valid <= 1'b0;
        end else if (!stall) begin
            result.valid <= issue_valid;
        end
        // hold everything while the arbiter cannot take it
        if (!stall && issue_valid) begin
            result.dest    <= issue.dest;
            result.rob_idx <= issue.rob_idx;
            result.value   <= value;
        end
    end

endmodule

`default_nettype wire

// File: logic/cdb_arbiter.sv
/*
 * CDB arbiter. One broadcast per cycle, multiply result first; the ALU
 * result waits in its unit while alu_busy is high.
 */
`default_nettype none

module cdb_arbiter (
    input  logic             clock,
    input  logic             reset,
    input  logic             flush,
    input  ooo_pkg::result_t alu_result,
    input  ooo_pkg::result_t mult_result,
    output ooo_pkg::cdb_t    cdb,
    output logic             alu_busy
);

    // both want the bus, the ALU loses this cycle
    assign alu_busy = alu_result.valid && mult_result.valid;

    ////////////////////////////////////////////////////////////////////////////
    // registered broadcast
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            cdb.valid <= 1'b0;   // in-flight results dropped on flush
        end else begin
            cdb.valid <= alu_result.valid || mult_result.valid;
        end

        if (mult_result.valid) begin
            cdb.tag     <= mult_result.dest;
            cdb.rob_idx <= mult_result.rob_idx;
            cdb.value   <= mult_result.value;
        end else if (alu_result.valid) begin
            cdb.tag     <= alu_result.dest;
            cdb.rob_idx <= alu_result.rob_idx;
            cdb.value   <= alu_result.value;
        end
    end

endmodule

`default_nettype wire

// File: logic/issue_top.sv
/*
 * Issue stage top level. Steers each dispatch to the ALU or multiply
 * station and connects stations, execution units and the CDB arbiter.
 */
`default_nettype none

module issue_top #(
    parameter int alu_rs_depth  = 4,
    parameter int mult_rs_depth = 2
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               flush,
    input  ooo_pkg::dispatch_t dispatch,
    output logic               alu_full,
    output logic               mult_full,
    output ooo_pkg::cdb_t      cdb
);
    import ooo_pkg::*;

    logic    alu_enable;
    logic    mult_enable;
    issue_t  alu_issue;
    issue_t  mult_issue;
    logic    alu_issue_valid;
    logic    mult_issue_valid;
    result_t alu_result;
    result_t mult_result;
    logic    alu_busy;          // arbiter back-pressure

    // dispatch steering
    assign mult_enable = dispatch.valid && is_mult(dispatch.op);
    assign alu_enable  = dispatch.valid && !is_mult(dispatch.op);

    ////////////////////////////////////////////////////////////////////////////
    // ALU path
    ////////////////////////////////////////////////////////////////////////////

    reservation_station #(.rs_depth(alu_rs_depth)) alu_rs (
        .clock, .reset, .flush,
        .enable      (alu_enable),
        .dispatch,
        .cdb,
        .hold        (alu_busy),
        .issue       (alu_issue),
        .issue_valid (alu_issue_valid),
        .full        (alu_full)
    );

    alu_exec alu_unit (
        .clock, .reset, .flush,
        .issue       (alu_issue),
        .issue_valid (alu_issue_valid),
        .stall       (alu_busy),
        .result      (alu_result)
    );

    ////////////////////////////////////////////////////////////////////////////
    // multiply path
    ////////////////////////////////////////////////////////////////////////////

    reservation_station #(.rs_depth(mult_rs_depth)) mult_rs (
        .clock, .reset, .flush,
        .enable      (mult_enable),
        .dispatch,
        .cdb,
        .hold        (1'b0),    // multiplier always wins the bus
        .issue       (mult_issue),
        .issue_valid (mult_issue_valid),
        .full        (mult_full)
    );

    mult_exec mult_unit (
        .clock, .reset, .flush,
        .issue       (mult_issue),
        .issue_valid (mult_issue_valid),
        .result      (mult_result)
    );

    cdb_arbiter arbiter (
        .clock, .reset, .flush,
        .alu_result, .mult_result,
        .cdb,
        .alu_busy
    );

endmodule

`default_nettype wire

// File: logic/mult_exec.sv
/*
 * Two-stage pipelined multiplier. Stage one forms the full unsigned
 * product, stage two picks the low or high half.
 */
`default_nettype none

module mult_exec (
    input  logic             clock,
    input  logic             reset,
    input  logic             flush,
    input  ooo_pkg::issue_t  issue,
    input  logic             issue_valid,
    output ooo_pkg::result_t result
);
    import ooo_pkg::*;

    // stage one
    logic                s1_valid;
    logic                s1_high;      // mulhu wants the upper word
    logic [prf_len-1:0]  s1_dest;
    logic [rob_len-1:0]  s1_rob_idx;
    logic [2*xlen-1:0]   s1_product;

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= issue_valid;
        end
        if (issue_valid) begin
            s1_high    <= (issue.op == op_mulhu);
            s1_dest    <= issue.dest;
            s1_rob_idx <= issue.rob_idx;
            s1_product <= (2 * xlen)'(issue.opa) * (2 * xlen)'(issue.opb);
        end
    end

    // stage two, half select
    always_ff @(posedge clock) begin
        if (reset || flush) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= s1_valid;
        end
        if (s1_valid) begin
            result.dest    <= s1_dest;
            result.rob_idx <= s1_rob_idx;
            result.value   <= s1_high ? s1_product[2*xlen-1:xlen] : s1_product[xlen-1:0];
        end
    end

endmodule

`default_nettype wire

// File: logic/ooo_pkg.sv
/*
 * Shared definitions for the out-of-order issue stage: data and tag widths,
 * operation codes, the operand union and the packets between the blocks.
 */
`default_nettype none

package ooo_pkg;

    localparam int xlen    = 32;   // data width
    localparam int prf_len = 6;    // physical register tag
    localparam int rob_len = 5;    // reorder buffer index

    typedef enum logic [3:0] {
        op_add   = 4'd0,
        op_sub   = 4'd1,
        op_and   = 4'd2,
        op_or    = 4'd3,
        op_xor   = 4'd4,
        op_slt   = 4'd5,   // signed compare
        op_sll   = 4'd6,
        op_srl   = 4'd7,
        op_mul   = 4'd8,   // low product
        op_mulhu = 4'd9    // high product, unsigned
    } op_e;

    // tag view of an operand word
    typedef struct packed {
        logic [xlen-prf_len-1:0] pad;   // zero above the tag
        logic [prf_len-1:0]      tag;
    } phys_tag_t;

    // one word: either the value or the producer's tag
    typedef union packed {
        logic [xlen-1:0] value;
        phys_tag_t       phys;
    } operand_u;

    typedef struct packed {
        logic     ready;   // opnd holds a value when set
        operand_u opnd;
    } src_t;

    typedef struct packed {
        logic               valid;
        op_e                op;
        src_t               src_a;
        src_t               src_b;
        logic [prf_len-1:0] dest;
        logic [rob_len-1:0] rob_idx;
    } dispatch_t;

    typedef struct packed {
        op_e                op;
        logic [xlen-1:0]    opa;
        logic [xlen-1:0]    opb;
        logic [prf_len-1:0] dest;
        logic [rob_len-1:0] rob_idx;
    } issue_t;

    typedef struct packed {
        logic               valid;
        logic [prf_len-1:0] dest;
        logic [rob_len-1:0] rob_idx;
        logic [xlen-1:0]    value;
    } result_t;

    typedef struct packed {
        logic               valid;
        logic [prf_len-1:0] tag;
        logic [rob_len-1:0] rob_idx;
        logic [xlen-1:0]    value;
    } cdb_t;

    // multiplies go to their own station
    function automatic logic is_mult(input op_e op);
        return (op == op_mul) || (op == op_mulhu);
    endfunction

endpackage

`default_nettype wire

// File: logic/reservation_station.sv
/*
 * Reservation station. Holds renamed instructions until both operands
 * are ready, wakes them from the CDB by tag and issues the lowest ready
 * slot, one per cycle.
 */
`default_nettype none

module reservation_station #(
    parameter int rs_depth = 4
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               flush,
    input  logic               enable,
    input  ooo_pkg::dispatch_t dispatch,
    input  ooo_pkg::cdb_t      cdb,
    input  logic               hold,
    output ooo_pkg::issue_t    issue,
    output logic               issue_valid,
    output logic               full
);
    import ooo_pkg::*;

    localparam int idx_len = (rs_depth > 1) ? $clog2(rs_depth) : 1;
    localparam int cnt_len = $clog2(rs_depth + 1);

    dispatch_t           entries [rs_depth];
    logic [rs_depth-1:0] free;          // slot is empty
    logic [cnt_len-1:0]  count;         // occupied slots
    logic [rs_depth-1:0] ready;         // occupied with both operands
    logic [idx_len-1:0]  free_idx;
    logic [idx_len-1:0]  issue_idx;
    logic                accept;
    logic                issue_go;
    dispatch_t           incoming;      // dispatch after CDB bypass

    // take the broadcast value if this operand waits on its tag
    function automatic src_t wake(input src_t src, input cdb_t bus);
        src_t woken;
        woken = src;
        if (!src.ready && bus.valid && (src.opnd.phys.tag == bus.tag)) begin
            woken.ready      = 1'b1;
            woken.opnd.value = bus.value;
        end
        return woken;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // slot selection
    ////////////////////////////////////////////////////////////////////////////

    assign full     = (count == cnt_len'(rs_depth));
    assign accept   = enable && dispatch.valid && !full;   // dropped when full
    assign issue_go = (|ready) && !hold;

    always_comb begin
        for (int i = 0; i < rs_depth; i++) begin
            ready[i] = !free[i] && entries[i].src_a.ready && entries[i].src_b.ready;
        end
    end

    // lowest free slot and lowest ready slot
    always_comb begin
        free_idx  = '0;
        issue_idx = '0;
        for (int i = rs_depth - 1; i >= 0; i--) begin
            if (free[i]) free_idx = idx_len'(i);
            if (ready[i]) issue_idx = idx_len'(i);
        end
    end

    always_comb begin
        incoming       = dispatch;
        incoming.src_a = wake(dispatch.src_a, cdb);   // same-cycle bypass
        incoming.src_b = wake(dispatch.src_b, cdb);
    end

    ////////////////////////////////////////////////////////////////////////////
    // control state
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            free        <= '1;
            count       <= '0;
            issue_valid <= 1'b0;
        end else begin
            if (accept) begin
                free[free_idx] <= 1'b0;
            end
            if (issue_go) begin
                free[issue_idx] <= 1'b1;   // slot reusable next cycle
            end
            // under hold the last issue stays put for the unit
            if (!hold) begin
                issue_valid <= issue_go;
            end
            count <= count + cnt_len'(accept) - cnt_len'(issue_go);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // entry payload and issue register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        for (int i = 0; i < rs_depth; i++) begin
            entries[i].src_a <= wake(entries[i].src_a, cdb);
            entries[i].src_b <= wake(entries[i].src_b, cdb);
        end
        if (accept) begin
            entries[free_idx] <= incoming;   // free slot, wakeup above does not apply
        end
        if (issue_go) begin
            issue.op      <= entries[issue_idx].op;
            issue.opa     <= entries[issue_idx].src_a.opnd.value;
            issue.opb     <= entries[issue_idx].src_b.opnd.value;
            issue.dest    <= entries[issue_idx].dest;
            issue.rob_idx <= entries[issue_idx].rob_idx;
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the issue stage testbench with Verilator.
# A crash or a stopped run counts as a failure in the log.
cd "$(dirname "$0")" \
    && rm -f sim.log \
    && verilator --binary --timing --assert --top-module issue_tb -f verilog.f -o issue_sim \
    && { ./obj_dir/issue_sim > sim.log 2>&1 || echo "*** TEST FAILED ***" >> sim.log; } \
    && cat sim.log \
    && ! grep -q -F "*** TEST FAILED ***" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: testbench/clock_gen.sv
/*
 * Testbench clock and reset: period of 4 time units, reset high for the
 * first five rising edges.
 */
`default_nettype none

module clock_gen (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        repeat (5) @(posedge clock);
        reset <= 1'b0;
    end

    always #2 clock = ~clock;

endmodule

`default_nettype wire

// File: testbench/issue_assert.sv
/*
 * Concurrent checks on the issue stage: quiet CDB after reset and flush,
 * no dispatch into a full station, clean arbitration and ALU back-pressure.
 */
`default_nettype none

module issue_assert (
    input logic             clock,
    input logic             reset,
    input logic             flush,
    input logic             alu_enable,
    input logic             mult_enable,
    input logic             alu_full,
    input logic             mult_full,
    input logic             alu_busy,
    input ooo_pkg::issue_t  alu_issue,
    input ooo_pkg::result_t alu_result,
    input ooo_pkg::result_t mult_result,
    input ooo_pkg::cdb_t    cdb
);

    cdb_quiet: assert property (@(posedge clock) (reset || flush) |=> !cdb.valid)
        else $error("CDB valid in the cycle after reset or flush");

    alu_room: assert property (@(posedge clock) disable iff (reset) alu_enable |-> !alu_full)
        else $error("dispatch sent to the full ALU station");

    mult_room: assert property (@(posedge clock) disable iff (reset) mult_enable |-> !mult_full)
        else $error("dispatch sent to the full multiply station");

    // multiply goes out first, ALU result waits untouched
    no_collision: assert property (@(posedge clock) disable iff (reset || flush)
        alu_busy |=> cdb.valid && (cdb.rob_idx == $past(mult_result.rob_idx))
                     && alu_result.valid && $stable(alu_result))
        else $error("ALU and multiply results collided on the CDB");

    busy_stops_issue: assert property (@(posedge clock) disable iff (reset)
        alu_busy |=> $stable(alu_issue))
        else $error("ALU station issued while the arbiter was busy");

endmodule

bind issue_top issue_assert checks (
    .clock, .reset, .flush, .alu_enable, .mult_enable, .alu_full, .mult_full,
    .alu_busy, .alu_issue, .alu_result, .mult_result, .cdb
);

`default_nettype wire

// File: testbench/issue_tb.sv
/*
 * Issue stage testbench. Sends renamed instructions to the DUT and checks
 * every CDB broadcast against a reference model kept by rob index.
 */
`default_nettype none

module issue_tb;
    import ooo_pkg::*;

    logic      clock;
    logic      reset;
    logic      flush;
    dispatch_t dispatch;
    logic      alu_full;
    logic      mult_full;
    cdb_t      cdb;

    // expected results by rob index
    logic [xlen-1:0]    exp_value [32];
    logic [prf_len-1:0] exp_tag   [32];
    logic               exp_valid [32] = '{default: 1'b0};
    logic               got       [32] = '{default: 1'b0};   // seen on the CDB
    int disp_edge [32];   // edge that samples the dispatch
    int done_edge [32];   // edge after which the CDB carries it
    int cycle = 0;
    int sent = 0;
    int done = 0;
    int bus_errors = 0;
    int stim_errors = 0;
    int timeouts = 0;
    int errors_seen = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    clock_gen clocks (.clock, .reset);

    issue_top #(.alu_rs_depth(4), .mult_rs_depth(2)) DUT (
        .clock, .reset, .flush, .dispatch, .alu_full, .mult_full, .cdb
    );

    function automatic logic [xlen-1:0] model(input op_e op, input logic [xlen-1:0] a,
                                              input logic [xlen-1:0] b);
        logic [2*xlen-1:0] p;
        p = {{xlen{1'b0}}, a} * {{xlen{1'b0}}, b};
        case (op)
            op_add:   return a + b;
            op_sub:   return a - b;
            op_and:   return a & b;
            op_or:    return a | b;
            op_xor:   return a ^ b;
            op_slt:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            op_sll:   return a << b[4:0];
            op_srl:   return a >> b[4:0];
            op_mul:   return p[xlen-1:0];
            default:  return p[2*xlen-1:xlen];   // mulhu
        endcase
    endfunction

    function automatic src_t value_src(input logic [xlen-1:0] v);
        src_t s;
        s.ready      = 1'b1;
        s.opnd.value = v;
        return s;
    endfunction

    function automatic src_t tag_src(input logic [prf_len-1:0] t);
        src_t s;
        s.ready          = 1'b0;
        s.opnd.phys.pad  = '0;
        s.opnd.phys.tag  = t;
        return s;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // CDB monitor
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (!reset && cdb.valid) begin
            assert (exp_valid[cdb.rob_idx] && !got[cdb.rob_idx] &&
                    cdb.tag == exp_tag[cdb.rob_idx] && cdb.value == exp_value[cdb.rob_idx])
            else begin
                $display("Fail at %0t: rob_idx %0d broadcast tag %0d value %h", $time,
                         cdb.rob_idx, cdb.tag, cdb.value);
                bus_errors++;
            end
            got[cdb.rob_idx]       <= 1'b1;
            done_edge[cdb.rob_idx] <= cycle - 1;
            done                   <= done + 1;
        end
    end

    task automatic send(input op_e op, input src_t sa, input src_t sb,
                        input logic [rob_len-1:0] rob, input logic [xlen-1:0] want);
        dispatch_t d;
        d.valid   = 1'b1;
        d.op      = op;
        d.src_a   = sa;
        d.src_b   = sb;
        d.dest    = prf_len'(rob + 1);   // dest tag follows the rob index
        d.rob_idx = rob;
        @(posedge clock);
        dispatch       <= d;
        exp_valid[rob] <= 1'b1;
        exp_tag[rob]   <= d.dest;
        exp_value[rob] <= want;
        disp_edge[rob] <= cycle + 1;
        sent           <= sent + 1;
    endtask

    task automatic idle();
        @(posedge clock);
        dispatch.valid <= 1'b0;
    endtask

    task automatic wait_results(input string what);
        int waited;
        waited = 0;
        while (done != sent && waited < 200) begin
            @(posedge clock);
            waited++;
        end
        if (done != sent) begin
            $display("timeout: %s still missing %0d CDB results", what, sent - done);
            timeouts++;
        end
    endtask

    task automatic wait_reset_release();
        int waited;
        waited = 0;
        do begin
            @(posedge clock);
            waited++;
        end while (reset && waited < 50);
        if (reset) begin
            $display("timeout: reset was never released");
            timeouts++;
        end
    endtask

    task automatic check_latency(input logic [rob_len-1:0] rob, input int cycles);
        assert (done_edge[rob] - disp_edge[rob] == cycles)
        else begin
            $display("Fail at %0t: rob_idx %0d took %0d cycles, expected %0d", $time, rob,
                     done_edge[rob] - disp_edge[rob], cycles);
            stim_errors++;
        end
    endtask

    task automatic close_test(input string name);
        int errors;
        errors = bus_errors + stim_errors + timeouts;
        if (errors == errors_seen) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: failed", name);
        end
        errors_seen = errors;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int seed;
        logic [xlen-1:0] a, b, c, p;
        op_e op;
        seed = 55;
        flush    <= 1'b0;
        dispatch <= '0;
        wait_reset_release();

        for (int i = 0; i < 8; i++) begin
            a  = $random(seed);
            b  = $random(seed);
            op = op_e'(i);
            send(op, value_src(a), value_src(b), rob_len'(i), model(op, a, b));
        end
        idle();
        wait_results("ALU opcodes");
        send(op_add, value_src(a), value_src(b), 5'd8, model(op_add, a, b));   // alone
        idle();
        wait_results("lone add");
        check_latency(5'd8, 3);
        close_test("alu opcodes");

        a = $random(seed);
        b = $random(seed);
        send(op_mul, value_src(a), value_src(b), 5'd9, model(op_mul, a, b));
        send(op_mulhu, value_src(b), value_src(a), 5'd10, model(op_mulhu, b, a));
        idle();
        wait_results("back-to-back multiplies");
        send(op_mulhu, value_src(a), value_src(a), 5'd11, model(op_mulhu, a, a));
        idle();
        wait_results("lone mulhu");
        check_latency(5'd11, 4);
        close_test("multiplies");

        // add waits on tag 13 from the mul
        c = $random(seed);
        p = model(op_mul, a, b);
        send(op_mul, value_src(a), value_src(b), 5'd12, p);
        send(op_add, tag_src(6'd13), value_src(c), 5'd13, model(op_add, p, c));
        idle();
        wait_results("dependent add");
        // consumer sampled on the edge that sees its producer on the CDB
        p = model(op_sub, a, b);
        send(op_sub, value_src(a), value_src(b), 5'd14, p);
        idle();
        repeat (2) @(posedge clock);
        send(op_xor, tag_src(6'd15), value_src(c), 5'd15, model(op_xor, p, c));
        idle();
        wait_results("bypassed xor");
        check_latency(5'd15, 3);
        close_test("dependency chain");

        send(op_mul, value_src(a), value_src(c), 5'd16, model(op_mul, a, c));
        send(op_add, value_src(b), value_src(c), 5'd17, model(op_add, b, c));
        idle();
        // ready just as the arbiter turns busy
        send(op_or, value_src(a), value_src(b), 5'd18, model(op_or, a, b));
        idle();
        wait_results("conflicting results");
        assert (done_edge[16] < done_edge[17])
        else begin
            $display("Fail at %0t: multiply did not reach the CDB before the add", $time);
            stim_errors++;
        end
        close_test("cdb conflict");

        // nothing produces tag 63 so these stay put
        for (int i = 19; i < 23; i++) begin
            send(op_add, tag_src(6'd63), value_src(a), rob_len'(i), '0);
        end
        idle();
        assert (!alu_full)
        else begin
            $display("Fail at %0t: alu_full high with three entries", $time);
            stim_errors++;
        end
        @(posedge clock);
        assert (alu_full)
        else begin
            $display("Fail at %0t: alu_full low with four entries", $time);
            stim_errors++;
        end
        close_test("alu capacity");

        // two products in flight and two multiplies stuck on tag 63
        send(op_mul, value_src(a), value_src(b), 5'd23, model(op_mul, a, b));
        send(op_mulhu, value_src(a), value_src(c), 5'd24, model(op_mulhu, a, c));
        send(op_mul, tag_src(6'd63), value_src(a), 5'd25, '0);
        send(op_mul, tag_src(6'd63), value_src(b), 5'd26, '0);
        idle();
        flush <= 1'b1;   // one product leaving the unit and one in stage one
        for (int i = 0; i < 32; i++) begin
            exp_valid[i] <= 1'b0;
        end
        @(posedge clock);
        assert (alu_full && mult_full)
        else begin
            $display("Fail at %0t: stations not full before flush", $time);
            stim_errors++;
        end
        flush <= 1'b0;
        sent  <= done;
        repeat (8) @(posedge clock);   // nothing may broadcast after the flush
        assert (!alu_full && !mult_full)
        else begin
            $display("Fail at %0t: station still full after flush", $time);
            stim_errors++;
        end
        send(op_sub, value_src(c), value_src(a), 5'd27, model(op_sub, c, a));
        send(op_mulhu, value_src(c), value_src(b), 5'd28, model(op_mulhu, c, b));
        idle();
        wait_results("work after flush");
        close_test("flush");

        $display("%0d tests ok, %0d tests failed, %0d check errors, %0d timeouts",
                 tests_passed, tests_failed, bus_errors + stim_errors, timeouts);
        if (tests_failed == 0 && bus_errors + stim_errors + timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
logic/ooo_pkg.sv
logic/reservation_station.sv
logic/alu_exec.sv
logic/mult_exec.sv
logic/cdb_arbiter.sv
logic/issue_top.sv
testbench/clock_gen.sv
testbench/issue_assert.sv
testbench/issue_tb.sv
